// File: src.f
source/imuldiv_pkg.sv
source/imuldiv_mul_dpath.sv
source/imuldiv_mul_ctrl.sv
source/imuldiv_div_unit.sv
source/imuldiv_front.sv
source/imuldiv_top.sv
verification/imuldiv_sva.sv
verification/imuldiv_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the multiply/divide testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module imuldiv_tb -f src.f \
  --Mdir obj_dir -o imuldiv_sim

# the simulator exits non-zero on a fatal error, the search below decides
output=$(./obj_dir/imuldiv_sim 2>&1 || true)
echo "$output"

if grep -qx "TEST PASS" <<< "$output"; then
  exit 0
fi
exit 1

// File: verification/imuldiv_tb.sv
// directed testbench for the multiply/divide unit
// drives imuldiv_top over val/rdy, checks values, latency and ordering
`timescale 1ns/10ps

module imuldiv_tb;

  localparam int ORDER_DEPTH = 2;
  // cycles any single wait may take before the run is abandoned
  localparam int TIMEOUT = 200;
  // lone request on an idle unit, accept to resp_val
  localparam int LONE_LATENCY = 33;

  logic                     clk;
  logic                     reset;
  logic                     req_val;
  imuldiv_pkg::muldiv_req_t req_msg;
  logic                     req_rdy;
  logic                     resp_val;
  imuldiv_pkg::dword_t      resp_msg;
  logic                     resp_rdy;
  integer                   seed;

  imuldiv_top #(
    .ORDER_DEPTH (ORDER_DEPTH)
  ) i_imuldiv_top (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_msg  (req_msg),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_msg (resp_msg),
    .resp_rdy (resp_rdy)
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ----------------------------------------
  // failure reporting and compares
  // ----------------------------------------

  task automatic stop_with_failure();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped after the first error");
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    stop_with_failure();
  endtask

  task automatic check_dword(input imuldiv_pkg::dword_t got, input imuldiv_pkg::dword_t exp,
                             input string what);
    if (got !== exp) begin
      $display("Fail at %0t: %s, got %h, expected %h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_latency(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("Fail at %0t: %s, latency %0d cycles, expected %0d", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0t: %s, got %b, expected %b", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  // ----------------------------------------
  // reference results
  // ----------------------------------------

  // division rules: x/0 gives all ones and x rem 0 gives x,
  // min/-1 gives min with remainder 0, results zero-extended
  function automatic imuldiv_pkg::dword_t expected_result(input imuldiv_pkg::fn_t fn,
                                                          input imuldiv_pkg::word_t a,
                                                          input imuldiv_pkg::word_t b);
    int                 sa;
    int                 sb;
    longint             sa64;
    longint             sb64;
    logic               ovf;
    imuldiv_pkg::word_t low;
    sa   = a;
    sb   = b;
    sa64 = sa;
    sb64 = sb;
    ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    low  = '0;
    case (fn)
      imuldiv_pkg::FN_MUL: begin
        return imuldiv_pkg::dword_t'(sa64 * sb64);
      end
      imuldiv_pkg::FN_DIV: begin
        if (b == '0) low = '1;
        else if (ovf) low = a;
        else low = imuldiv_pkg::word_t'(sa / sb);
      end
      imuldiv_pkg::FN_REM: begin
        if (b == '0) low = a;
        else if (ovf) low = '0;
        else low = imuldiv_pkg::word_t'(sa % sb);
      end
      imuldiv_pkg::FN_DIVU: begin
        if (b == '0) low = '1;
        else low = a / b;
      end
      imuldiv_pkg::FN_REMU: begin
        if (b == '0) low = a;
        else low = a % b;
      end
      default: begin
        low = 'x;
      end
    endcase
    return {32'b0, low};
  endfunction

  // ----------------------------------------
  // bus handling
  // ----------------------------------------

  // called 2 ns after a rising edge, returns 2 ns after the accept edge
  task automatic send_req(input imuldiv_pkg::fn_t fn, input imuldiv_pkg::word_t a,
                          input imuldiv_pkg::word_t b);
    int waited;
    waited      = 0;
    req_msg.fn  = fn;
    req_msg.a   = a;
    req_msg.b   = b;
    req_val     = 1'b1;
    @(negedge clk);
    while (!req_rdy) begin
      waited++;
      if (waited > TIMEOUT) report_timeout("req_rdy");
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    req_val = 1'b0;
  endtask

  // counts falling edges until resp_val shows up
  task automatic wait_resp_val(output int cycles, input string what);
    cycles = 1;
    @(negedge clk);
    while (!resp_val) begin
      if (cycles > TIMEOUT) report_timeout(what);
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic receive_resp(output imuldiv_pkg::dword_t got, output int cycles);
    resp_rdy = 1'b1;
    wait_resp_val(cycles, "resp_val");
    // sampled mid-cycle, well away from the edge
    got = resp_msg;
    @(posedge clk);
    #2;
    resp_rdy = 1'b0;
  endtask

  // one request on an idle unit, value and latency both checked
  task automatic run_one(input imuldiv_pkg::fn_t fn, input imuldiv_pkg::word_t a,
                         input imuldiv_pkg::word_t b);
    imuldiv_pkg::dword_t got;
    int                  cycles;
    string               what;
    what = $sformatf("fn %0d a=%h b=%h", fn, a, b);
    send_req(fn, a, b);
    receive_resp(got, cycles);
    check_latency(cycles, LONE_LATENCY, what);
    check_dword(got, expected_result(fn, a, b), what);
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------

  task automatic test_mul_corners();
    imuldiv_pkg::word_t ma [10] = '{32'd0, 32'd1, 32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0000,
                                    32'h8000_0000, 32'hffff_fffd, 32'd1234567, 32'h8000_0000,
                                    32'h7fff_ffff};
    imuldiv_pkg::word_t mb [10] = '{32'd5, 32'hffff_ffff, 32'hffff_ffff, 32'h7fff_ffff,
                                    32'h8000_0000, 32'h7fff_ffff, 32'd12345, 32'hffff_ffa7,
                                    32'hffff_ffff, 32'd1};
    for (int i = 0; i < 10; i++) begin
      run_one(imuldiv_pkg::FN_MUL, ma[i], mb[i]);
    end
  endtask

  task automatic test_div_ops();
    imuldiv_pkg::fn_t   fns [4] = '{imuldiv_pkg::FN_DIV, imuldiv_pkg::FN_DIVU,
                                    imuldiv_pkg::FN_REM, imuldiv_pkg::FN_REMU};
    imuldiv_pkg::word_t da [7] = '{32'd100, 32'hffff_ff9c, 32'd100, 32'hffff_ff9c,
                                   32'hffff_fff0, 32'd7, 32'h8000_0001};
    imuldiv_pkg::word_t db [7] = '{32'd7, 32'd7, 32'hffff_fff9, 32'hffff_fff9,
                                   32'd3, 32'd100, 32'd2};
    for (int i = 0; i < 7; i++) begin
      for (int f = 0; f < 4; f++) begin
        run_one(fns[f], da[i], db[i]);
      end
    end
  endtask

  task automatic test_div_special();
    // zero divisor with positive, negative and zero dividends
    run_one(imuldiv_pkg::FN_DIV, 32'd42, 32'd0);
    run_one(imuldiv_pkg::FN_REM, 32'hffff_ffd6, 32'd0);
    run_one(imuldiv_pkg::FN_DIVU, 32'hdead_beef, 32'd0);
    run_one(imuldiv_pkg::FN_REMU, 32'hdead_beef, 32'd0);
    run_one(imuldiv_pkg::FN_DIV, 32'd0, 32'd0);
    // signed overflow, and the same operands taken unsigned
    run_one(imuldiv_pkg::FN_DIV, 32'h8000_0000, 32'hffff_ffff);
    run_one(imuldiv_pkg::FN_REM, 32'h8000_0000, 32'hffff_ffff);
    run_one(imuldiv_pkg::FN_DIVU, 32'h8000_0000, 32'hffff_ffff);
  endtask

  task automatic test_backpressure();
    imuldiv_pkg::dword_t held;
    imuldiv_pkg::dword_t got;
    int                  cycles;
    resp_rdy = 1'b0;
    send_req(imuldiv_pkg::FN_MUL, 32'hfedc_ba98, 32'h0123_4567);
    wait_resp_val(cycles, "resp_val under back-pressure");
    held = resp_msg;
    check_dword(held, expected_result(imuldiv_pkg::FN_MUL, 32'hfedc_ba98, 32'h0123_4567),
                "held product");
    // probe only, val stays low: multiplier sits in done
    @(posedge clk);
    #2;
    req_msg.fn = imuldiv_pkg::FN_MUL;
    @(negedge clk);
    check_flag(req_rdy, 1'b0, "req_rdy for busy multiplier");
    @(posedge clk);
    #2;
    // divider is idle and the queue has one free slot
    send_req(imuldiv_pkg::FN_DIVU, 32'd1000, 32'd9);
    req_msg.fn = imuldiv_pkg::FN_REM;
    @(negedge clk);
    check_flag(req_rdy, 1'b0, "req_rdy with full order queue");
    repeat (40) begin
      @(negedge clk);
      check_flag(resp_val, 1'b1, "resp_val under back-pressure");
      check_dword(resp_msg, held, "resp_msg under back-pressure");
    end
    @(posedge clk);
    #2;
    // release, product first, then the waiting quotient
    receive_resp(got, cycles);
    check_dword(got, held, "product after release");
    receive_resp(got, cycles);
    check_dword(got, expected_result(imuldiv_pkg::FN_DIVU, 32'd1000, 32'd9),
                "quotient after release");
  endtask

  task automatic test_random_stream();
    imuldiv_pkg::dword_t exp_q [$];
    fork
      begin
        imuldiv_pkg::word_t r;
        imuldiv_pkg::word_t a;
        imuldiv_pkg::word_t b;
        imuldiv_pkg::fn_t   fn;
        for (int i = 0; i < 40; i++) begin
          r  = $random(seed);
          a  = $random(seed);
          b  = $random(seed);
          fn = imuldiv_pkg::fn_t'(r % 32'd5);
          // narrow divisors now and then, zero once in a while
          b  = b >> r[8:4];
          if (r[12:9] == 4'd0) b = '0;
          send_req(fn, a, b);
          exp_q.push_back(expected_result(fn, a, b));
        end
      end
      begin
        imuldiv_pkg::dword_t got;
        int                  cycles;
        for (int j = 0; j < 40; j++) begin
          receive_resp(got, cycles);
          if (exp_q.size() == 0) begin
            $display("response %0d arrived with no request outstanding", j);
            stop_with_failure();
          end
          check_dword(got, exp_q.pop_front(), $sformatf("stream response %0d", j));
        end
      end
    join
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    seed     = 32'h06c7_92b8;
    reset    = 1'b1;
    req_val  = 1'b0;
    req_msg  = '0;
    resp_rdy = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
    test_mul_corners();
    test_div_ops();
    test_div_special();
    test_backpressure();
    test_random_stream();
    $display("TEST PASS");
    $finish;
  end

endmodule

// File: verification/imuldiv_sva.sv
// handshake assertions for the multiply/divide unit
// bound to imuldiv_top, keeps its own count of requests in flight
`timescale 1ns/10ps

module imuldiv_sva #(
  parameter int ORDER_DEPTH = 2
) (
  input logic                clk,
  input logic                reset,
  input logic                req_val,
  input logic                req_rdy,
  input logic                resp_val,
  input imuldiv_pkg::dword_t resp_msg,
  input logic                resp_rdy
);

  // accepted requests not yet answered
  int in_flight;

  always_ff @(posedge clk) begin
    if (reset) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + ((req_val && req_rdy) ? 1 : 0)
                             - ((resp_val && resp_rdy) ? 1 : 0);
    end
  end

  // a stalled response keeps its valid and its data
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_msg))
    else $error("response changed while stalled");

  // no new request once the order queue is full
  a_full_rdy: assert property (@(posedge clk) disable iff (reset)
    in_flight == ORDER_DEPTH |-> !req_rdy)
    else $error("req_rdy high with full order queue");

  a_reset_val: assert property (@(posedge clk) reset |=> !resp_val)
    else $error("resp_val high during reset");

endmodule

bind imuldiv_top imuldiv_sva #(
  .ORDER_DEPTH (ORDER_DEPTH)
) i_imuldiv_sva (
  .clk      (clk),
  .reset    (reset),
  .req_val  (req_val),
  .req_rdy  (req_rdy),
  .resp_val (resp_val),
  .resp_msg (resp_msg),
  .resp_rdy (resp_rdy)
);

// File: source/imuldiv_top.sv
// top level of the integer multiply/divide unit
// joins the front end to the multiplier ctrl/dpath pair and the divider
`timescale 1ns/10ps

module imuldiv_top #(
  parameter int ORDER_DEPTH = 2
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_val,
  input  imuldiv_pkg::muldiv_req_t req_msg,
  output logic                     req_rdy,
  output logic                     resp_val,
  output imuldiv_pkg::dword_t      resp_msg,
  input  logic                     resp_rdy
);

  // multiplier links
  logic                   mul_req_val;
  imuldiv_pkg::mul_req_t  mul_req_msg;
  logic                   mul_req_rdy;
  logic                   mul_resp_val;
  imuldiv_pkg::dword_t    mul_resp_msg;
  logic                   mul_resp_rdy;
  logic                   a_en;
  logic                   a_mux_sel;
  logic                   b_en;
  logic                   b_mux_sel;

  // divider links
  logic                   div_req_val;
  imuldiv_pkg::div_req_t  div_req_msg;
  logic                   div_req_rdy;
  logic                   div_resp_val;
  imuldiv_pkg::div_resp_t div_resp_msg;
  logic                   div_resp_rdy;

  imuldiv_front #(
    .ORDER_DEPTH (ORDER_DEPTH)
  ) i_front (
    .clk          (clk),
    .reset        (reset),
    .req_val      (req_val),
    .req_msg      (req_msg),
    .req_rdy      (req_rdy),
    .resp_val     (resp_val),
    .resp_msg     (resp_msg),
    .resp_rdy     (resp_rdy),
    .mul_req_val  (mul_req_val),
    .mul_req_msg  (mul_req_msg),
    .mul_req_rdy  (mul_req_rdy),
    .mul_resp_val (mul_resp_val),
    .mul_resp_msg (mul_resp_msg),
    .mul_resp_rdy (mul_resp_rdy),
    .div_req_val  (div_req_val),
    .div_req_msg  (div_req_msg),
    .div_req_rdy  (div_req_rdy),
    .div_resp_val (div_resp_val),
    .div_resp_msg (div_resp_msg),
    .div_resp_rdy (div_resp_rdy)
  );

  imuldiv_mul_dpath i_mul_dpath (
    .clk         (clk),
    .reset       (reset),
    .mul_req_msg (mul_req_msg),
    .a_en        (a_en),
    .a_mux_sel   (a_mux_sel),
    .b_en        (b_en),
    .b_mux_sel   (b_mux_sel),
    .result      (mul_resp_msg)
  );

  imuldiv_mul_ctrl i_mul_ctrl (
    .clk       (clk),
    .reset     (reset),
    .req_val   (mul_req_val),
    .req_rdy   (mul_req_rdy),
    .resp_val  (mul_resp_val),
    .resp_rdy  (mul_resp_rdy),
    .a_en      (a_en),
    .a_mux_sel (a_mux_sel),
    .b_en      (b_en),
    .b_mux_sel (b_mux_sel)
  );

  imuldiv_div_unit i_div_unit (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_msg  (div_req_msg),
    .req_rdy  (div_req_rdy),
    .resp_val (div_resp_val),
    .resp_msg (div_resp_msg),
    .resp_rdy (div_resp_rdy)
  );

endmodule

// File: source/imuldiv_front.sv
// front end of the multiply/divide unit
// routes each request by function code and returns responses in request order
`timescale 1ns/10ps

module imuldiv_front #(
  parameter int ORDER_DEPTH = 2
) (
  input  logic                     clk,
  input  logic                     reset,
  // outside side
  input  logic                     req_val,
  input  imuldiv_pkg::muldiv_req_t req_msg,
  output logic                     req_rdy,
  output logic                     resp_val,
  output imuldiv_pkg::dword_t      resp_msg,
  input  logic                     resp_rdy,
  // multiplier side
  output logic                     mul_req_val,
  output imuldiv_pkg::mul_req_t    mul_req_msg,
  input  logic                     mul_req_rdy,
  input  logic                     mul_resp_val,
  input  imuldiv_pkg::dword_t      mul_resp_msg,
  output logic                     mul_resp_rdy,
  // divider side
  output logic                     div_req_val,
  output imuldiv_pkg::div_req_t    div_req_msg,
  input  logic                     div_req_rdy,
  input  logic                     div_resp_val,
  input  imuldiv_pkg::div_resp_t   div_resp_msg,
  output logic                     div_resp_rdy
);

  localparam int PTR_W = (ORDER_DEPTH > 1) ? $clog2(ORDER_DEPTH) : 1;
  localparam int CNT_W = $clog2(ORDER_DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;

  // order queue of function codes, oldest at rd_ptr
  imuldiv_pkg::fn_t order_q [ORDER_DEPTH];
  ptr_t             wr_ptr;
  ptr_t             rd_ptr;
  logic [CNT_W-1:0] order_count;
  logic             order_full;
  logic             order_empty;

  imuldiv_pkg::fn_t head_fn;
  logic             req_is_mul;
  logic             head_is_mul;
  logic             head_is_rem;
  logic             req_fire;
  logic             resp_fire;

  function automatic ptr_t next_ptr(input ptr_t p);
    return (p == PTR_W'(ORDER_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign order_full  = (order_count == CNT_W'(ORDER_DEPTH));
  assign order_empty = (order_count == '0);

  // ----------------------------------------
  // request dispatch
  // ----------------------------------------

  // every code other than mul goes to the divider
  assign req_is_mul = (req_msg.fn == imuldiv_pkg::FN_MUL);

  // a unit only sees val while the queue has room for its entry
  assign mul_req_val = req_val && req_is_mul && !order_full;
  assign div_req_val = req_val && !req_is_mul && !order_full;
  assign req_rdy     = !order_full && (req_is_mul ? mul_req_rdy : div_req_rdy);
  assign req_fire    = req_val && req_rdy;

  always_comb begin
    mul_req_msg.a         = req_msg.a;
    mul_req_msg.b         = req_msg.b;
    div_req_msg.a         = req_msg.a;
    div_req_msg.b         = req_msg.b;
    div_req_msg.is_signed = (req_msg.fn == imuldiv_pkg::FN_DIV)
                         || (req_msg.fn == imuldiv_pkg::FN_REM);
  end

  // ----------------------------------------
  // order queue
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (req_fire) begin
      order_q[wr_ptr] <= req_msg.fn;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      order_count <= '0;
    end else begin
      if (req_fire) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (resp_fire) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // push and pop in one cycle leave the count alone
      case ({req_fire, resp_fire})
        2'b10:   order_count <= order_count + 1'b1;
        2'b01:   order_count <= order_count - 1'b1;
        default: order_count <= order_count;
      endcase
    end
  end

  // ----------------------------------------
  // response selection
  // ----------------------------------------

  assign head_fn     = order_q[rd_ptr];
  assign head_is_mul = (head_fn == imuldiv_pkg::FN_MUL);
  assign head_is_rem = (head_fn == imuldiv_pkg::FN_REM)
                    || (head_fn == imuldiv_pkg::FN_REMU);

  // only the unit at the head may hand over its result
  assign resp_val     = !order_empty && (head_is_mul ? mul_resp_val : div_resp_val);
  assign mul_resp_rdy = !order_empty && head_is_mul && resp_rdy;
  assign div_resp_rdy = !order_empty && !head_is_mul && resp_rdy;
  assign resp_fire    = resp_val && resp_rdy;

  // division results are zero-extended into the low word
  always_comb begin
    if (head_is_mul) begin
      resp_msg = mul_resp_msg;
    end else if (head_is_rem) begin
      resp_msg = {32'b0, div_resp_msg.rem};
    end else begin
      resp_msg = {32'b0, div_resp_msg.quot};
    end
  end

endmodule

// File: source/imuldiv_div_unit.sv
// iterative restoring divider, signed or unsigned per request
// 32 steps over a combined remainder/quotient register, result held in done
`timescale 1ns/10ps

module imuldiv_div_unit (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req_val,
  input  imuldiv_pkg::div_req_t  req_msg,
  output logic                   req_rdy,
  output logic                   resp_val,
  output imuldiv_pkg::div_resp_t resp_msg,
  input  logic                   resp_rdy
);

  imuldiv_pkg::div_state_e state;
  logic [4:0] count;

  logic req_fire;
  logic resp_fire;

  // operand magnitudes at load
  logic               a_neg;
  logic               b_neg;
  imuldiv_pkg::word_t a_mag;
  imuldiv_pkg::word_t b_mag;

  // upper half is the partial remainder, lower half shifts in quotient bits
  logic [63:0]        rq_reg;
  imuldiv_pkg::word_t dvsr_reg;
  logic               neg_quot_reg;
  logic               neg_rem_reg;
  logic               div_zero_reg;

  // one restoring step
  logic [32:0] partial;
  logic [32:0] trial;
  logic        take_sub;

  imuldiv_pkg::word_t quot_mag;
  imuldiv_pkg::word_t rem_mag;

  assign req_fire  = req_val && req_rdy;
  assign resp_fire = resp_val && resp_rdy;

  assign req_rdy  = (state == imuldiv_pkg::DIV_IDLE);
  assign resp_val = (state == imuldiv_pkg::DIV_DONE);

  // ----------------------------------------
  // state and counter
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::DIV_IDLE;
      count <= '0;
    end else begin
      case (state)
        imuldiv_pkg::DIV_IDLE: begin
          if (req_fire) begin
            state <= imuldiv_pkg::DIV_CALC;
            count <= '0;
          end
        end
        imuldiv_pkg::DIV_CALC: begin
          if (count == 5'd31) begin
            state <= imuldiv_pkg::DIV_DONE;
          end
          count <= count + 5'd1;
        end
        imuldiv_pkg::DIV_DONE: begin
          if (resp_fire) begin
            state <= imuldiv_pkg::DIV_IDLE;
          end
        end
        default: begin
          state <= imuldiv_pkg::DIV_IDLE;
        end
      endcase
    end
  end

  // ----------------------------------------
  // datapath
  // ----------------------------------------

  // unsigned requests never take the negative path
  assign a_neg = req_msg.is_signed && req_msg.a[31];
  assign b_neg = req_msg.is_signed && req_msg.b[31];
  assign a_mag = a_neg ? -req_msg.a : req_msg.a;
  assign b_mag = b_neg ? -req_msg.b : req_msg.b;

  // shifted remainder is 33 bits, the top bit comes out of rq_reg[63]
  assign partial  = rq_reg[63:31];
  assign trial    = partial - {1'b0, dvsr_reg};
  assign take_sub = (partial >= {1'b0, dvsr_reg});

  always_ff @(posedge clk) begin
    if (req_fire) begin
      rq_reg       <= {32'b0, a_mag};
      dvsr_reg     <= b_mag;
      neg_quot_reg <= a_neg ^ b_neg;
      // remainder follows the dividend sign
      neg_rem_reg  <= a_neg;
      div_zero_reg <= (req_msg.b == '0);
    end else if (state == imuldiv_pkg::DIV_CALC) begin
      if (take_sub) begin
        rq_reg <= {trial[31:0], rq_reg[30:0], 1'b1};
      end else begin
        rq_reg <= {rq_reg[62:0], 1'b0};
      end
    end
  end

  // ----------------------------------------
  // result
  // ----------------------------------------

  assign quot_mag = rq_reg[31:0];
  assign rem_mag  = rq_reg[63:32];

  // with a zero divisor every step subtracts nothing, so the remainder
  // already ends up as the dividend and only the quotient is forced
  always_comb begin
    if (div_zero_reg) begin
      resp_msg.quot = '1;
    end else if (neg_quot_reg) begin
      resp_msg.quot = -quot_mag;
    end else begin
      resp_msg.quot = quot_mag;
    end
    resp_msg.rem = neg_rem_reg ? -rem_mag : rem_mag;
  end

endmodule

// File: source/imuldiv_mul_ctrl.sv
// control unit of the iterative multiplier
// idle/calc/done FSM that drives the datapath enables and the val/rdy pair
`timescale 1ns/10ps

module imuldiv_mul_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic a_en,
  output logic a_mux_sel,
  output logic b_en,
  output logic b_mux_sel
);

  imuldiv_pkg::mul_state_e state;
  // iteration counter, one step per multiplier bit
  logic [4:0] count;

  logic req_fire;
  logic resp_fire;

  assign req_fire  = req_val && req_rdy;
  assign resp_fire = resp_val && resp_rdy;

  // ----------------------------------------
  // state and counter
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::MUL_IDLE;
      count <= '0;
    end else begin
      case (state)
        imuldiv_pkg::MUL_IDLE: begin
          if (req_fire) begin
            state <= imuldiv_pkg::MUL_CALC;
            count <= '0;
          end
        end
        imuldiv_pkg::MUL_CALC: begin
          // 32 steps, counter runs 0 to 31
          if (count == 5'd31) begin
            state <= imuldiv_pkg::MUL_DONE;
          end
          count <= count + 5'd1;
        end
        imuldiv_pkg::MUL_DONE: begin
          // result held here until the front end takes it
          if (resp_fire) begin
            state <= imuldiv_pkg::MUL_IDLE;
          end
        end
        default: begin
          state <= imuldiv_pkg::MUL_IDLE;
        end
      endcase
    end
  end

  // ----------------------------------------
  // outputs
  // ----------------------------------------

  always_comb begin
    req_rdy   = 1'b0;
    resp_val  = 1'b0;
    a_en      = 1'b0;
    a_mux_sel = 1'b0;
    b_en      = 1'b0;
    b_mux_sel = 1'b0;
    case (state)
      imuldiv_pkg::MUL_IDLE: begin
        req_rdy = 1'b1;
        // load the operands on the accept edge
        a_en    = req_fire;
        b_en    = req_fire;
      end
      imuldiv_pkg::MUL_CALC: begin
        // shift and accumulate every cycle
        a_en      = 1'b1;
        a_mux_sel = 1'b1;
        b_en      = 1'b1;
        b_mux_sel = 1'b1;
      end
      imuldiv_pkg::MUL_DONE: begin
        resp_val = 1'b1;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

endmodule

// File: source/imuldiv_mul_dpath.sv
// datapath of the iterative signed multiplier
// operand registers and shift-add accumulator, steered by imuldiv_mul_ctrl
`timescale 1ns/10ps

module imuldiv_mul_dpath (
  input  logic                  clk,
  input  logic                  reset,
  input  imuldiv_pkg::mul_req_t mul_req_msg,
  input  logic                  a_en,
  input  logic                  a_mux_sel,
  input  logic                  b_en,
  input  logic                  b_mux_sel,
  output imuldiv_pkg::dword_t   result
);

  // operand sign bits, taken straight from the request
  logic sign_a;
  logic sign_b;
  // magnitudes of the request operands
  imuldiv_pkg::word_t mag_a;
  imuldiv_pkg::word_t mag_b;

  // a is kept 64 bits wide so it can shift left 32 times
  imuldiv_pkg::dword_t a_reg;
  imuldiv_pkg::word_t  b_reg;
  imuldiv_pkg::dword_t acc_reg;
  logic                sign_a_reg;
  logic                sign_b_reg;

  imuldiv_pkg::dword_t a_next;
  imuldiv_pkg::word_t  b_next;
  imuldiv_pkg::dword_t acc_next;

  // ----------------------------------------
  // operand preparation
  // ----------------------------------------

  assign sign_a = mul_req_msg.a[31];
  assign sign_b = mul_req_msg.b[31];
  assign mag_a  = sign_a ? -mul_req_msg.a : mul_req_msg.a;
  assign mag_b  = sign_b ? -mul_req_msg.b : mul_req_msg.b;

  // mux select low loads a new operand, high takes the shifted value
  assign a_next = a_mux_sel ? (a_reg << 1) : {32'b0, mag_a};
  assign b_next = b_mux_sel ? (b_reg >> 1) : mag_b;

  // add the shifted multiplicand when the current multiplier bit is set
  assign acc_next = b_reg[0] ? (acc_reg + a_reg) : acc_reg;

  // ----------------------------------------
  // registers
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_next;
    end
    if (b_en) begin
      b_reg <= b_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      acc_reg    <= '0;
      sign_a_reg <= 1'b0;
      sign_b_reg <= 1'b0;
    end else if (a_en && !a_mux_sel) begin
      // load cycle, remember signs and start from zero
      acc_reg    <= '0;
      sign_a_reg <= sign_a;
      sign_b_reg <= sign_b;
    end else if (a_en && a_mux_sel) begin
      acc_reg <= acc_next;
    end
  end

  // sign fix-up of the unsigned product
  assign result = (sign_a_reg ^ sign_b_reg) ? -acc_reg : acc_reg;

endmodule

// File: source/imuldiv_pkg.sv
// shared types for the integer multiply/divide unit
// function codes, request and response structs, and the unit state machines
package imuldiv_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------

  // one 32-bit operand or division result
  typedef logic [31:0] word_t;
  // full response word, product or zero-extended division result
  typedef logic [63:0] dword_t;
  typedef logic [2:0] fn_t;

  // ----------------------------------------
  // function codes
  // ----------------------------------------

  localparam fn_t FN_MUL  = 3'd0;
  localparam fn_t FN_DIV  = 3'd1;
  localparam fn_t FN_DIVU = 3'd2;
  localparam fn_t FN_REM  = 3'd3;
  localparam fn_t FN_REMU = 3'd4;

  // ----------------------------------------
  // messages
  // ----------------------------------------

  // outside request, 67 bits
  typedef struct packed {
    fn_t   fn;
    word_t a;
    word_t b;
  } muldiv_req_t;

  // multiplier request, 64 bits
  typedef struct packed {
    word_t a;
    word_t b;
  } mul_req_t;

  // divider request, 65 bits
  // a is the dividend, b the divisor
  typedef struct packed {
    word_t a;
    word_t b;
    logic  is_signed;
  } div_req_t;

  // divider response, 64 bits
  typedef struct packed {
    word_t quot;
    word_t rem;
  } div_resp_t;

  // ----------------------------------------
  // state machines
  // ----------------------------------------

  typedef enum logic [1:0] {
    MUL_IDLE,
    MUL_CALC,
    MUL_DONE
  } mul_state_e;

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_CALC,
    DIV_DONE
  } div_state_e;

endpackage
